/* logic/shipPkg.sv */
package shipPkg;

	// Fleet shape
	localparam int NumShips = 12;
	localparam int MaxShipLen = 5;

	// Ship number 1 to 12, zero when no ship is active
	localparam int ShipNumWidth = 4;
	localparam int LenWidth = 3;

	// Length of each ship in placement order
	localparam logic [LenWidth-1:0] fleetLen [1:NumShips] = '{
		3'd2,
		3'd2,
		3'd2,
		3'd2,
		3'd3,
		3'd3,
		3'd3,
		3'd3,
		3'd4,
		3'd4,
		3'd4,
		3'd5
	};

	// Tile word fields, from the top bit down
	//   ship number, vertical flag, segment kind, offset from the head
	localparam int KindWidth = 2;
	localparam int OffsetWidth = 3;
	localparam int TileWidth = ShipNumWidth + 1 + KindWidth + OffsetWidth;

	// Segment kinds as stored in a tile
	// An empty cell is segNone with every other field zero
	typedef enum logic [KindWidth-1:0] {
		segNone,
		segHead,
		segBody,
		segTail
	} segKind_t;

	// Placement FSM states
	typedef enum logic [1:0] {
		// Waiting for the board clear and the display
		stInit,
		// Player moves and rotates the current ship
		stAim,
		// Segments of the current ship being written
		stPlace,
		// All ships placed
		stDone
	} placeState_t;

endpackage

/* logic/occupancyMap.sv */
`timescale 1ns/1ps

module occupancyMap #(
	parameter int BoardSide = 16
) (
	input  logic                              Clock,
	input  logic                              rstN,
	input  logic                              MarkValid,
	input  logic [$clog2(BoardSide)-1:0]      MarkRow,
	input  logic [$clog2(BoardSide)-1:0]      MarkCol,
	input  logic [$clog2(BoardSide)-1:0]      CursorX,
	input  logic [$clog2(BoardSide)-1:0]      CursorY,
	input  logic [shipPkg::LenWidth-1:0]      ShipLen,
	input  logic                              Vertical,
	output logic                              CanPlace,
	output logic                              CanRotate
);

	import shipPkg::*;

	localparam int CoordWidth = $clog2(BoardSide);
	// One extra bit so that cursor plus length cannot wrap
	localparam int ExtWidth = CoordWidth + 1;

	logic [BoardSide-1:0][BoardSide-1:0] occupied;
	logic [ExtWidth-1:0] endX;
	logic [ExtWidth-1:0] endY;
	logic [ExtWidth-1:0] rowIdx;
	logic [ExtWidth-1:0] colIdx;
	logic fitsHoriz;
	logic fitsVert;
	logic hit;

	// Set a bit for every ship segment the board accepts
	always_ff @(posedge Clock) begin
		if (!rstN)
			occupied <= '0;
		else if (MarkValid)
			occupied[MarkRow][MarkCol] <= 1'b1;
	end

	// Board edge checks for both orientations
	assign endX = {1'b0, CursorX} + ExtWidth'(ShipLen);
	assign endY = {1'b0, CursorY} + ExtWidth'(ShipLen);
	assign fitsHoriz = (endX <= BoardSide);
	assign fitsVert = (endY <= BoardSide);

	// Any occupied cell under the footprint in the current orientation
	always_comb begin
		hit = 1'b0;
		rowIdx = {1'b0, CursorY};
		colIdx = {1'b0, CursorX};
		for (int i = 0; i < MaxShipLen; i++) begin
			rowIdx = Vertical ? {1'b0, CursorY} + ExtWidth'(i) : {1'b0, CursorY};
			colIdx = Vertical ? {1'b0, CursorX} : {1'b0, CursorX} + ExtWidth'(i);
			if (i < ShipLen && rowIdx < BoardSide && colIdx < BoardSide)
				hit = hit | occupied[rowIdx[CoordWidth-1:0]][colIdx[CoordWidth-1:0]];
		end
	end

	assign CanPlace = (Vertical ? fitsVert : fitsHoriz) & ~hit;
	// Rotation only needs room on the board, not free cells
	assign CanRotate = Vertical ? fitsHoriz : fitsVert;

endmodule

/* logic/tileWriter.sv */
`timescale 1ns/1ps

module tileWriter #(
	parameter int BoardSide = 16
) (
	input  logic                               Clock,
	input  logic                               rstN,
	input  logic                               PlaceStart,
	input  logic [shipPkg::ShipNumWidth-1:0]   ShipNum,
	input  logic [shipPkg::LenWidth-1:0]       ShipLen,
	input  logic                               Vertical,
	input  logic [$clog2(BoardSide)-1:0]       CursorX,
	input  logic [$clog2(BoardSide)-1:0]       CursorY,
	input  logic                               WriteReady,
	output logic                               ClearDone,
	output logic                               PlaceDone,
	output logic                               WriteValid,
	output logic [$clog2(BoardSide)-1:0]       WriteRow,
	output logic [$clog2(BoardSide)-1:0]       WriteCol,
	output logic [shipPkg::TileWidth-1:0]      WriteData,
	output logic                               MarkValid,
	output logic [$clog2(BoardSide)-1:0]       MarkRow,
	output logic [$clog2(BoardSide)-1:0]       MarkCol
);

	import shipPkg::*;

	localparam int CoordWidth = $clog2(BoardSide);
	localparam int CellWidth = 2 * CoordWidth;

	typedef enum logic [1:0] {
		wrStart,
		wrClear,
		wrIdle,
		wrPlace
	} writerState_t;

	writerState_t state;
	logic [CellWidth-1:0] cellCnt;
	logic [OffsetWidth-1:0] segOff;
	logic [CoordWidth-1:0] segStep;
	logic accept;
	logic lastSeg;
	segKind_t segKind;

	// Ship held for the whole placement
	logic [ShipNumWidth-1:0] shipReg;
	logic [LenWidth-1:0] lenReg;
	logic vertReg;
	logic [CoordWidth-1:0] headRow;
	logic [CoordWidth-1:0] headCol;

	assign WriteValid = (state == wrClear) || (state == wrPlace);
	assign ClearDone = (state == wrIdle) || (state == wrPlace);
	assign accept = WriteValid & WriteReady;
	assign lastSeg = (segOff == lenReg - LenWidth'(1));
	assign segStep = CoordWidth'(segOff);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= wrStart;
			cellCnt <= '0;
			segOff <= '0;
		end else begin
			case (state)
				wrStart: state <= wrClear;
				wrClear: begin
					if (accept) begin
						cellCnt <= cellCnt + CellWidth'(1);
						if (cellCnt == '1)
							state <= wrIdle;
					end
				end
				wrIdle: begin
					if (PlaceStart) begin
						segOff <= '0;
						state <= wrPlace;
					end
				end
				default: begin
					if (accept) begin
						segOff <= segOff + OffsetWidth'(1);
						if (lastSeg)
							state <= wrIdle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (state == wrIdle && PlaceStart) begin
			shipReg <= ShipNum;
			lenReg <= ShipLen;
			vertReg <= Vertical;
			headRow <= CursorY;
			headCol <= CursorX;
		end
	end

	always_comb begin
		if (segOff == '0)
			segKind = segHead;
		else if (lastSeg)
			segKind = segTail;
		else
			segKind = segBody;
	end

	// Clear sweep walks the cell counter, row in the upper half
	always_comb begin
		WriteRow = cellCnt[CellWidth-1:CoordWidth];
		WriteCol = cellCnt[CoordWidth-1:0];
		WriteData = {ShipNumWidth'(0), 1'b0, segNone, OffsetWidth'(0)};
		if (state == wrPlace) begin
			WriteRow = vertReg ? headRow + segStep : headRow;
			WriteCol = vertReg ? headCol : headCol + segStep;
			WriteData = {shipReg, vertReg, segKind, segOff};
		end
	end

	assign PlaceDone = accept && (state == wrPlace) && lastSeg;
	assign MarkValid = accept && (state == wrPlace);
	assign MarkRow = WriteRow;
	assign MarkCol = WriteCol;

endmodule

/* logic/placementFsm.sv */
`timescale 1ns/1ps

module placementFsm (
	input  logic                               Clock,
	input  logic                               rstN,
	input  logic                               InitDone,
	input  logic                               AButton,
	input  logic                               RButton,
	input  logic                               ClearDone,
	input  logic                               PlaceDone,
	input  logic                               CanPlace,
	input  logic                               CanRotate,
	output logic                               PlaceStart,
	output logic [shipPkg::ShipNumWidth-1:0]   ShipNum,
	output logic [shipPkg::LenWidth-1:0]       ShipLen,
	output logic                               Vertical,
	output logic                               Horiz,
	output logic                               NewCursor,
	output logic                               SetDone
);

	import shipPkg::*;

	placeState_t state;
	logic rotate;
	logic lastShip;

	// Rotate wins over place when both buttons arrive together
	assign rotate = (state == stAim) & RButton & CanRotate;
	assign PlaceStart = (state == stAim) & AButton & ~RButton & CanPlace;

	assign lastShip = (ShipNum == ShipNumWidth'(NumShips));
	assign NewCursor = (state == stPlace) & PlaceDone;
	assign SetDone = (state == stDone);
	assign Horiz = ~Vertical;

	// Length of the active ship, zero once the fleet is done
	always_comb begin
		ShipLen = '0;
		if (ShipNum != '0 && ShipNum <= NumShips)
			ShipLen = fleetLen[ShipNum];
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= stInit;
			ShipNum <= ShipNumWidth'(1);
			Vertical <= 1'b0;
		end else begin
			case (state)
				stInit: begin
					// Board cleared and display ready
					if (ClearDone && InitDone)
						state <= stAim;
				end
				stAim: begin
					if (rotate)
						Vertical <= ~Vertical;
					else if (PlaceStart)
						state <= stPlace;
				end
				stPlace: begin
					if (PlaceDone) begin
						// Next ship always starts horizontal
						Vertical <= 1'b0;
						if (lastShip) begin
							ShipNum <= '0;
							state <= stDone;
						end else begin
							ShipNum <= ShipNum + ShipNumWidth'(1);
							state <= stAim;
						end
					end
				end
				default: begin
					// Fleet complete, hold here until reset
					state <= stDone;
				end
			endcase
		end
	end

endmodule

/* logic/boardPlacer.sv */
`timescale 1ns/1ps

module boardPlacer #(
	parameter int BoardSide = 16
) (
	input  logic                               Clock,
	input  logic                               rstN,
	input  logic [$clog2(BoardSide)-1:0]       CursorX,
	input  logic [$clog2(BoardSide)-1:0]       CursorY,
	input  logic                               AButton,
	input  logic                               RButton,
	input  logic                               InitDone,
	input  logic                               WriteReady,
	output logic                               WriteValid,
	output logic [$clog2(BoardSide)-1:0]       WriteRow,
	output logic [$clog2(BoardSide)-1:0]       WriteCol,
	output logic [shipPkg::TileWidth-1:0]      WriteData,
	output logic                               NewCursor,
	output logic                               Horiz,
	output logic [shipPkg::LenWidth-1:0]       ShipLen,
	output logic [shipPkg::ShipNumWidth-1:0]   ShipNum,
	output logic                               SetDone
);

	localparam int CoordWidth = $clog2(BoardSide);

	logic placeStart;
	logic placeDone;
	logic clearDone;
	logic vertical;
	logic canPlace;
	logic canRotate;
	logic markValid;
	logic [CoordWidth-1:0] markRow;
	logic [CoordWidth-1:0] markCol;

	placementFsm u_placementFsm (
		.Clock      (Clock),
		.rstN       (rstN),
		.InitDone   (InitDone),
		.AButton    (AButton),
		.RButton    (RButton),
		.ClearDone  (clearDone),
		.PlaceDone  (placeDone),
		.CanPlace   (canPlace),
		.CanRotate  (canRotate),
		.PlaceStart (placeStart),
		.ShipNum    (ShipNum),
		.ShipLen    (ShipLen),
		.Vertical   (vertical),
		.Horiz      (Horiz),
		.NewCursor  (NewCursor),
		.SetDone    (SetDone)
	);

	tileWriter #(
		.BoardSide (BoardSide)
	) u_tileWriter (
		.Clock      (Clock),
		.rstN       (rstN),
		.PlaceStart (placeStart),
		.ShipNum    (ShipNum),
		.ShipLen    (ShipLen),
		.Vertical   (vertical),
		.CursorX    (CursorX),
		.CursorY    (CursorY),
		.WriteReady (WriteReady),
		.ClearDone  (clearDone),
		.PlaceDone  (placeDone),
		.WriteValid (WriteValid),
		.WriteRow   (WriteRow),
		.WriteCol   (WriteCol),
		.WriteData  (WriteData),
		.MarkValid  (markValid),
		.MarkRow    (markRow),
		.MarkCol    (markCol)
	);

	occupancyMap #(
		.BoardSide (BoardSide)
	) u_occupancyMap (
		.Clock     (Clock),
		.rstN      (rstN),
		.MarkValid (markValid),
		.MarkRow   (markRow),
		.MarkCol   (markCol),
		.CursorX   (CursorX),
		.CursorY   (CursorY),
		.ShipLen   (ShipLen),
		.Vertical  (vertical),
		.CanPlace  (canPlace),
		.CanRotate (canRotate)
	);

endmodule

/* verif/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
	parameter int ClockPeriod = 10,
	parameter int ResetCycles = 8
) (
	output logic Clock,
	output logic rstN
);

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	// Reset released just after a rising edge
	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		#1 rstN = 1'b1;
	end

endmodule

/* verif/boardPlacerTb.sv */
`timescale 1ns/1ps

module boardPlacerTb;

	localparam int BoardSide = 16;
	localparam int CoordWidth = $clog2(BoardSide);
	localparam int Cells = BoardSide * BoardSide;
	localparam int NumTests = 5;
	localparam int TimeoutCycles = 20 * Cells + 200 * NumTests;
	localparam int KindHead = 1;
	localparam int KindBody = 2;
	localparam int KindTail = 3;
	localparam int FleetLen [12] = '{2, 2, 2, 2, 3, 3, 3, 3, 4, 4, 4, 5};

	logic Clock;
	logic rstN;
	logic [CoordWidth-1:0] CursorX;
	logic [CoordWidth-1:0] CursorY;
	logic AButton;
	logic RButton;
	logic InitDone;
	logic WriteReady;
	logic WriteValid;
	logic [CoordWidth-1:0] WriteRow;
	logic [CoordWidth-1:0] WriteCol;
	logic [9:0] WriteData;
	logic NewCursor;
	logic Horiz;
	logic [2:0] ShipLen;
	logic [3:0] ShipNum;
	logic SetDone;

	// Board memory model, write log and expected board
	logic [9:0] boardMem [Cells];
	int expBoard [Cells];
	int wrRowQ [$];
	int wrColQ [$];
	int wrDataQ [$];
	int writeCount;
	int newCursorCount;
	logic stalledPrev;
	int heldRow;
	int heldCol;
	int heldData;

	clockGen u_clockGen (.Clock(Clock), .rstN(rstN));

	boardPlacer #(.BoardSide(BoardSide)) u_boardPlacer (
		.Clock(Clock), .rstN(rstN), .CursorX(CursorX), .CursorY(CursorY),
		.AButton(AButton), .RButton(RButton), .InitDone(InitDone), .WriteReady(WriteReady),
		.WriteValid(WriteValid), .WriteRow(WriteRow), .WriteCol(WriteCol),
		.WriteData(WriteData), .NewCursor(NewCursor), .Horiz(Horiz), .ShipLen(ShipLen),
		.ShipNum(ShipNum), .SetDone(SetDone)
	);

	task automatic checkValue(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[FAIL] time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Tile word from ship number, vertical flag, kind and offset
	function automatic int tileWord(input int shipNum, input int vert, input int off,
			input int len);
		int kind;
		if (off == 0)
			kind = KindHead;
		else if (off == len - 1)
			kind = KindTail;
		else
			kind = KindBody;
		return (shipNum << 6) | (vert << 5) | (kind << 3) | off;
	endfunction

	// Random back-pressure with about one stall in four
	initial begin
		void'($urandom(19));
		WriteReady = 1'b0;
		forever begin
			@(posedge Clock);
			#1;
			WriteReady = ($urandom % 4) != 0;
		end
	end

	always @(posedge Clock) begin
		if (!rstN) begin
			stalledPrev = 1'b0;
			writeCount = 0;
			newCursorCount = 0;
			for (int i = 0; i < Cells; i++)
				boardMem[i] = 10'h200 | 10'(i);
		end else begin
			// A stalled write must hold
			if (stalledPrev) begin
				checkValue("WriteValid under stall", 1, int'(WriteValid));
				checkValue("WriteRow under stall", heldRow, int'(WriteRow));
				checkValue("WriteCol under stall", heldCol, int'(WriteCol));
				checkValue("WriteData under stall", heldData, int'(WriteData));
			end
			if (WriteValid && WriteReady) begin
				boardMem[int'(WriteRow) * BoardSide + int'(WriteCol)] = WriteData;
				wrRowQ.push_back(int'(WriteRow));
				wrColQ.push_back(int'(WriteCol));
				wrDataQ.push_back(int'(WriteData));
				writeCount++;
			end
			if (NewCursor)
				newCursorCount++;
			stalledPrev = WriteValid && !WriteReady;
			heldRow = int'(WriteRow);
			heldCol = int'(WriteCol);
			heldData = int'(WriteData);
		end
	end

	initial begin
		repeat (TimeoutCycles) @(posedge Clock);
		$display("Timeout: the tests did not finish within %0d clock cycles", TimeoutCycles);
		$display("Result: FAILED");
		$fatal(1, "Simulation timed out");
	end

	task automatic moveCursor(input int x, input int y);
		@(posedge Clock);
		#1;
		CursorX = CoordWidth'(x);
		CursorY = CoordWidth'(y);
	endtask

	// One-cycle button pulse that returns at the following falling edge
	task automatic pressButtons(input logic a, input logic r);
		@(posedge Clock);
		#1;
		AButton = a;
		RButton = r;
		@(posedge Clock);
		#1;
		AButton = 1'b0;
		RButton = 1'b0;
		@(negedge Clock);
	endtask

	task automatic checkIdle(input int writesBefore, input int shipBefore);
		repeat (10) @(negedge Clock);
		checkValue("write count", writesBefore, writeCount);
		checkValue("ShipNum", shipBefore, int'(ShipNum));
		checkValue("WriteValid", 0, int'(WriteValid));
	endtask

	task automatic placeAndCheck(input int x, input int y, input int vert, input int shipNum);
		int len;
		int first;
		int cursorsBefore;
		int row;
		int col;
		len = FleetLen[shipNum - 1];
		moveCursor(x, y);
		@(negedge Clock);
		checkValue("ShipNum", shipNum, int'(ShipNum));
		checkValue("ShipLen", len, int'(ShipLen));
		checkValue("Horiz", 1 - vert, int'(Horiz));
		first = writeCount;
		cursorsBefore = newCursorCount;
		pressButtons(1'b1, 1'b0);
		while (newCursorCount == cursorsBefore)
			@(negedge Clock);
		@(negedge Clock);
		checkValue("NewCursor pulses", cursorsBefore + 1, newCursorCount);
		checkValue("segment writes", len, writeCount - first);
		for (int i = 0; i < len; i++) begin
			row = vert ? y + i : y;
			col = vert ? x : x + i;
			checkValue("segment row", row, wrRowQ[first + i]);
			checkValue("segment col", col, wrColQ[first + i]);
			checkValue("segment tile", tileWord(shipNum, vert, i, len), wrDataQ[first + i]);
			expBoard[row * BoardSide + col] = tileWord(shipNum, vert, i, len);
		end
		checkValue("Horiz on new ship", 1, int'(Horiz));
		checkValue("SetDone", shipNum == 12 ? 1 : 0, int'(SetDone));
		if (shipNum < 12)
			checkValue("ShipNum advanced", shipNum + 1, int'(ShipNum));
	endtask

	task automatic testClearSweep();
		@(posedge Clock);
		while (!rstN) begin
			@(negedge Clock);
			if (!rstN)
				checkValue("WriteValid in reset", 0, int'(WriteValid));
		end
		checkValue("SetDone after reset", 0, int'(SetDone));
		checkValue("NewCursor after reset", 0, int'(NewCursor));
		checkValue("ShipNum after reset", 1, int'(ShipNum));
		checkValue("Horiz after reset", 1, int'(Horiz));
		// Buttons during the sweep are ignored
		pressButtons(1'b0, 1'b1);
		checkValue("Horiz during sweep", 1, int'(Horiz));
		pressButtons(1'b1, 1'b0);
		while (writeCount < Cells)
			@(negedge Clock);
		for (int i = 0; i < Cells; i++) begin
			checkValue("clear row", i / BoardSide, wrRowQ[i]);
			checkValue("clear col", i % BoardSide, wrColQ[i]);
			checkValue("clear tile", 0, wrDataQ[i]);
			checkValue("cleared cell", 0, int'(boardMem[i]));
		end
		// Still no effect until InitDone
		pressButtons(1'b0, 1'b1);
		checkValue("Horiz before InitDone", 1, int'(Horiz));
		pressButtons(1'b1, 1'b0);
		checkIdle(Cells, 1);
		@(posedge Clock);
		#1;
		InitDone = 1'b1;
		@(negedge Clock);
	endtask

	task automatic testHorizontalPlacement();
		placeAndCheck(3, 2, 0, 1);
	endtask

	task automatic testRotation();
		// Off the bottom edge when vertical
		moveCursor(0, BoardSide - 1);
		pressButtons(1'b0, 1'b1);
		checkValue("Horiz at bottom edge", 1, int'(Horiz));
		// Both buttons only rotate
		moveCursor(6, 5);
		pressButtons(1'b1, 1'b1);
		checkValue("Horiz after rotate", 0, int'(Horiz));
		checkIdle(writeCount, 2);
		placeAndCheck(6, 5, 1, 2);
	endtask

	task automatic testRefusedPlacement();
		// Overlaps ship 1 and then crosses the right edge
		moveCursor(2, 2);
		pressButtons(1'b1, 1'b0);
		checkIdle(writeCount, 3);
		moveCursor(BoardSide - 1, 0);
		pressButtons(1'b1, 1'b0);
		checkIdle(writeCount, 3);
	endtask

	task automatic testFullFleet();
		for (int ship = 3; ship <= 11; ship++)
			placeAndCheck(0, ship + 4, 0, ship);
		moveCursor(BoardSide - 1, 0);
		pressButtons(1'b0, 1'b1);
		placeAndCheck(BoardSide - 1, 0, 1, 12);
		moveCursor(8, 8);
		pressButtons(1'b1, 1'b0);
		pressButtons(1'b1, 1'b1);
		// No ship is active once the fleet is complete
		checkIdle(writeCount, 0);
		checkValue("SetDone held", 1, int'(SetDone));
		for (int i = 0; i < Cells; i++)
			checkValue("final board tile", expBoard[i], int'(boardMem[i]));
	endtask

	initial begin
		CursorX = '0;
		CursorY = '0;
		AButton = 1'b0;
		RButton = 1'b0;
		InitDone = 1'b0;
		for (int i = 0; i < Cells; i++)
			expBoard[i] = 0;
		testClearSweep();
		testHorizontalPlacement();
		testRotation();
		testRefusedPlacement();
		testFullFleet();
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* sim.f */
logic/shipPkg.sv
logic/occupancyMap.sv
logic/tileWriter.sv
logic/placementFsm.sv
logic/boardPlacer.sv
verif/clockGen.sv
verif/boardPlacerTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module boardPlacerTb -o boardPlacerSim
./obj_dir/boardPlacerSim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "Simulation ended without a pass result"
	exit 1
fi
echo "Simulation passed"
